// File: flist.f
+incdir+src
src/puzzle_pkg.sv
src/move_ingress.sv
src/board_engine.sv
src/result_egress.sv
src/puzzle_solver_top.sv
dv/puzzle_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= puzzle_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell sed -n '/\.s\?v$$/p' $(FLIST)) src/puzzle_defines.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: dv/puzzle_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "puzzle_defines.svh"

module puzzle_tb import puzzle_pkg::*; ();

	// 2 + 9 + 10 + 3 directed, 1 + 200 random, 12 backlog
	localparam int NUM_CMDS = 237;
	localparam int CYCLE_LIMIT = 20 * NUM_CMDS + 200;

	logic clk = 1'b0;
	logic reset;
	logic move_valid;
	move_cmd_t move_cmd;
	logic move_credit;
	logic res_valid;
	move_result_t result;
	logic res_credit;

	integer seed = 32'h560a;
	int up_credit = `MOVE_FIFO_DEPTH;
	int credit_pulses = 0;
	int owed = 0;
	int gap = 0;
	logic hold_credits = 1'b0;
	int cycles = 0;
	int sent_cnt = 0;
	int recv_cnt = 0;
	int value_errors = 0;
	int other_errors = 0;
	int pulses_before;
	move_result_t exp_q[$];
	move_result_t expect_res;
	status_t last_status;
	board_t ref_board;
	pos_t ref_blank;
	count_t ref_count;

	puzzle_solver_top i_puzzle_solver_top (
		.clk(clk),
		.reset(reset),
		.move_valid(move_valid),
		.move_cmd(move_cmd),
		.move_credit(move_credit),
		.res_valid(res_valid),
		.result(result),
		.res_credit(res_credit)
	);

	always #5 clk = ~clk;

	function automatic board_t solved_board();
		board_t b;
		for (int i = 0; i < `BOARD_SIZE - 1; i++) begin
			b[i] = tile_t'(i + 1);
		end
		b[`BOARD_SIZE - 1] = '0;
		return b;
	endfunction

	// Hex digits read left to right as positions 0..8
	function automatic board_t row_major(logic [`TILE_W*`BOARD_SIZE-1:0] v);
		board_t b;
		for (int i = 0; i < `BOARD_SIZE; i++) begin
			b[i] = v[`TILE_W*(`BOARD_SIZE-1-i) +: `TILE_W];
		end
		return b;
	endfunction

	function automatic pos_t find_blank(board_t b);
		pos_t p;
		p = '0;
		for (int i = 0; i < `BOARD_SIZE; i++) begin
			if (b[i] == '0) p = pos_t'(i);
		end
		return p;
	endfunction

	function automatic move_result_t ref_step(board_t b, pos_t blank, count_t cnt,
			move_cmd_t c);
		move_result_t r;
		logic ok;
		int bl;
		int row;
		int col;
		int nb;
		bl = int'(blank);
		row = bl / `GRID_W;
		col = bl % `GRID_W;
		ok = 1'b1;
		nb = bl;
		r.board = b;
		r.count = cnt;
		if (c.op == CMD_LOAD) begin
			r.board = c.board;
			r.count = '0;
		end else begin
			case (c.dir)
				DIR_UP: begin
					ok = (row > 0);
					nb = bl - `GRID_W;
				end
				DIR_DOWN: begin
					ok = (row < `GRID_W - 1);
					nb = bl + `GRID_W;
				end
				DIR_RIGHT: begin
					ok = (col < `GRID_W - 1);
					nb = bl + 1;
				end
				default: begin
					ok = (col > 0);
					nb = bl - 1;
				end
			endcase
			if (ok) begin
				r.board[bl] = b[nb];
				r.board[nb] = '0;
				if (int'(cnt) < (1 << `COUNT_W) - 1) begin
					r.count = cnt + 1'b1;
				end
			end
		end
		if (r.board == solved_board()) r.status = ST_SOLVED;
		else if (!ok) r.status = ST_ILLEGAL;
		else r.status = ST_OK;
		return r;
	endfunction

	task automatic check_value(string what, logic [63:0] got, logic [63:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// Called 1 ns after a rising edge
	task automatic send_cmd(move_cmd_t c);
		move_result_t r;
		while (up_credit == 0) begin
			@(posedge clk);
			#1;
		end
		move_valid = 1'b1;
		move_cmd = c;
		up_credit--;
		sent_cnt++;
		r = ref_step(ref_board, ref_blank, ref_count, c);
		exp_q.push_back(r);
		ref_board = r.board;
		ref_count = r.count;
		ref_blank = find_blank(r.board);
		@(posedge clk);
		#1;
		move_valid = 1'b0;
	endtask

	task automatic send_load(board_t b);
		move_cmd_t c;
		c.op = CMD_LOAD;
		c.dir = DIR_UP;
		c.board = b;
		send_cmd(c);
	endtask

	task automatic send_move(dir_t d);
		move_cmd_t c;
		c.op = CMD_MOVE;
		c.dir = d;
		c.board = '0;
		send_cmd(c);
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || owed != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	always @(posedge clk) begin
		if (!reset && move_credit) begin
			up_credit++;
			credit_pulses++;
		end
	end

	// Downstream consumer returns each credit after a random gap
	always @(posedge clk) begin
		if (!reset && res_valid) owed++;
		#1;
		res_credit = 1'b0;
		if (!reset && !hold_credits && owed > 0) begin
			if (gap == 0) begin
				res_credit = 1'b1;
				owed--;
				gap = int'($unsigned($random(seed)) % 4);
			end else begin
				gap--;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && res_valid) begin
			recv_cnt++;
			last_status = result.status;
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("Result at %0t arrived with no command outstanding", $time);
			end else begin
				expect_res = exp_q.pop_front();
				check_value("status", 64'(result.status), 64'(expect_res.status));
				check_value("count", 64'(result.count), 64'(expect_res.count));
				check_value("board", 64'(result.board), 64'(expect_res.board));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles: results stopped arriving", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		move_valid = 1'b0;
		move_cmd = '0;
		res_credit = 1'b0;
		ref_board = solved_board();
		ref_blank = pos_t'(`BOARD_SIZE - 1);
		ref_count = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		send_load(solved_board());
		send_load(row_major(36'h813402765));

		// Every direction out of the center and back
		send_load(row_major(36'h123405678));
		send_move(DIR_UP);
		send_move(DIR_DOWN);
		send_move(DIR_RIGHT);
		send_move(DIR_LEFT);
		send_move(DIR_DOWN);
		send_move(DIR_UP);
		send_move(DIR_LEFT);
		send_move(DIR_RIGHT);

		// Edge rules as the blank walks the top row then the right column
		send_load(row_major(36'h012345678));
		send_move(DIR_UP);
		send_move(DIR_LEFT);
		send_move(DIR_RIGHT);
		send_move(DIR_RIGHT);
		send_move(DIR_RIGHT);
		send_move(DIR_UP);
		send_move(DIR_DOWN);
		send_move(DIR_DOWN);
		send_move(DIR_DOWN);

		// Two moves from solved
		send_load(row_major(36'h123405786));
		send_move(DIR_RIGHT);
		send_move(DIR_DOWN);
		drain();
		check_value("script ends solved", 64'(last_status), 64'(ST_SOLVED));

		send_load(row_major(36'h813402765));
		for (int i = 0; i < 200; i++) begin
			send_move(dir_t'($unsigned($random(seed)) % 4));
		end
		drain();

		// Stall with downstream credits withheld
		hold_credits = 1'b1;
		for (int i = 0; i < 12; i++) begin
			send_move(dir_t'($unsigned($random(seed)) % 4));
		end
		repeat (5) @(posedge clk);
		#1;
		pulses_before = credit_pulses;
		repeat (20) @(posedge clk);
		#1;
		check_value("move_credit pulses in stall", 64'(credit_pulses - pulses_before), 64'd0);
		check_value("upstream credits in stall", 64'(up_credit), 64'd0);
		check_value("results pending in stall", 64'(exp_q.size()), 64'd8);
		hold_credits = 1'b0;
		drain();
		repeat (5) @(posedge clk);

		check_value("results received", 64'(recv_cnt), 64'(sent_cnt));
		$display("Errors: %0d value mismatches, %0d other, %0d of %0d results checked",
			value_errors, other_errors, recv_cnt, sent_cnt);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src/puzzle_solver_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "puzzle_defines.svh"

module puzzle_solver_top import puzzle_pkg::*; (
	input wire clk,
	input wire reset,
	input logic move_valid,
	input move_cmd_t move_cmd,
	output logic move_credit,
	output logic res_valid,
	output move_result_t result,
	input logic res_credit
);

	logic cmd_valid;
	move_cmd_t cmd;
	logic cmd_pop;
	logic res_ready;
	logic res_push;
	move_result_t res;

	move_ingress i_move_ingress (
		.clk(clk),
		.reset(reset),
		.move_valid(move_valid),
		.move_cmd(move_cmd),
		.move_credit(move_credit),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_pop(cmd_pop)
	);

	board_engine i_board_engine (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_pop(cmd_pop),
		.res_ready(res_ready),
		.res_push(res_push),
		.res(res)
	);

	result_egress i_result_egress (
		.clk(clk),
		.reset(reset),
		.res_push(res_push),
		.res(res),
		.res_ready(res_ready),
		.res_valid(res_valid),
		.result(result),
		.res_credit(res_credit)
	);

endmodule

`default_nettype wire

// File: src/result_egress.sv
`timescale 1ns/100ps
`default_nettype none
`include "puzzle_defines.svh"

module result_egress import puzzle_pkg::*; (
	input wire clk,
	input wire reset,
	input logic res_push,
	input move_result_t res,
	output logic res_ready,
	output logic res_valid,
	output move_result_t result,
	input logic res_credit
);

	localparam int DEPTH = `RESULT_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);
	localparam int KW = $clog2(`RESULT_CREDITS + 1);

	move_result_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [KW-1:0] credit_cnt;
	logic send;

	assign res_ready = (count != CW'(DEPTH));

	// The credit behind a valid beat is still counted during that beat
	assign send = (count != '0) && (credit_cnt > KW'(res_valid));

	always_ff @(posedge clk) begin
		if (res_push) begin
			mem[wr_ptr] <= res;
		end
		if (send) begin
			result <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_cnt <= KW'(`RESULT_CREDITS);
			res_valid <= 1'b0;
		end else begin
			if (res_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(res_push) - CW'(send);
			credit_cnt <= credit_cnt - KW'(res_valid) + KW'(res_credit);
			res_valid <= send;
		end
	end

	assert property (@(posedge clk) disable iff (reset) credit_cnt <= KW'(`RESULT_CREDITS))
		else $error("result_egress: more credits returned than granted");

	assert property (@(posedge clk) disable iff (reset) res_valid |-> credit_cnt != '0)
		else $error("result_egress: result sent without a credit");

endmodule

`default_nettype wire

// File: src/board_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "puzzle_defines.svh"

module board_engine import puzzle_pkg::*; (
	input wire clk,
	input wire reset,
	input logic cmd_valid,
	input move_cmd_t cmd,
	output logic cmd_pop,
	input logic res_ready,
	output logic res_push,
	output move_result_t res
);

	board_t board_q;
	pos_t blank_q;
	count_t count_q;

	logic fire;
	pos_t load_blank;
	logic load_has_blank;
	pos_t blank_col;
	pos_t nbr;
	logic legal;
	board_t swap_board;
	board_t next_board;
	pos_t next_blank;
	count_t next_count;

	// One command per cycle, only when the result has a slot
	assign fire = cmd_valid && res_ready;
	assign cmd_pop = fire;
	assign res_push = fire;

	// Blank search over an incoming board
	always_comb begin
		load_blank = '0;
		load_has_blank = 1'b0;
		for (int i = `BOARD_SIZE - 1; i >= 0; i--) begin
			if (cmd.board[i] == '0) begin
				load_blank = pos_t'(i);
				load_has_blank = 1'b1;
			end
		end
	end

	// Edge rules and neighbor of the blank
	always_comb begin
		blank_col = pos_t'(blank_q % `GRID_W);
		legal = 1'b0;
		nbr = blank_q;
		case (cmd.dir)
			DIR_UP: begin
				legal = (blank_q >= pos_t'(`GRID_W));
				nbr = blank_q - pos_t'(`GRID_W);
			end
			DIR_DOWN: begin
				legal = (blank_q < pos_t'(`BOARD_SIZE - `GRID_W));
				nbr = blank_q + pos_t'(`GRID_W);
			end
			DIR_RIGHT: begin
				legal = (blank_col != pos_t'(`GRID_W - 1));
				nbr = blank_q + 1'b1;
			end
			DIR_LEFT: begin
				legal = (blank_col != '0);
				nbr = blank_q - 1'b1;
			end
		endcase
		swap_board = board_q;
		if (legal) begin
			swap_board[blank_q] = board_q[nbr];
			swap_board[nbr] = '0;
		end
	end

	always_comb begin
		next_board = board_q;
		next_blank = blank_q;
		next_count = count_q;
		if (cmd.op == CMD_LOAD) begin
			next_board = cmd.board;
			next_blank = load_blank;
			next_count = '0;
		end else if (legal) begin
			next_board = swap_board;
			next_blank = nbr;
			// Counter sticks at all ones
			next_count = (count_q == '1) ? count_q : count_q + 1'b1;
		end
		res.board = next_board;
		res.count = next_count;
		if (next_board == GOAL_BOARD) begin
			res.status = ST_SOLVED;
		end else if (cmd.op == CMD_MOVE && !legal) begin
			res.status = ST_ILLEGAL;
		end else begin
			res.status = ST_OK;
		end
	end

	// Starts out at the goal with the blank in the corner
	always_ff @(posedge clk) begin
		if (reset) begin
			board_q <= GOAL_BOARD;
			blank_q <= pos_t'(`BOARD_SIZE - 1);
			count_q <= '0;
		end else if (fire) begin
			board_q <= next_board;
			blank_q <= next_blank;
			count_q <= next_count;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(fire && cmd.op == CMD_LOAD) |-> load_has_blank)
		else $error("board_engine: loaded board has no blank");

	// Blank tracking must stay in step with the board across swaps
	assert property (@(posedge clk) disable iff (reset) board_q[blank_q] == '0)
		else $error("board_engine: blank position points at tile %0d", board_q[blank_q]);

endmodule

`default_nettype wire

// File: src/move_ingress.sv
`timescale 1ns/100ps
`default_nettype none
`include "puzzle_defines.svh"

module move_ingress import puzzle_pkg::*; (
	input wire clk,
	input wire reset,
	input logic move_valid,
	input move_cmd_t move_cmd,
	output logic move_credit,
	output logic cmd_valid,
	output move_cmd_t cmd,
	input logic cmd_pop
);

	localparam int DEPTH = `MOVE_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	move_cmd_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic full;

	assign full = (count == CW'(DEPTH));
	assign cmd_valid = (count != '0);
	assign cmd = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (move_valid) begin
			mem[wr_ptr] <= move_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			move_credit <= 1'b0;
		end else begin
			if (move_valid) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (cmd_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(move_valid) - CW'(cmd_pop);
			// One credit back per freed slot
			move_credit <= cmd_pop;
		end
	end

	// Sender ran past its credits
	assert property (@(posedge clk) disable iff (reset) move_valid |-> !full)
		else $error("move_ingress: command received with FIFO full");

endmodule

`default_nettype wire

// File: src/puzzle_pkg.sv
`default_nettype none
`include "puzzle_defines.svh"

package puzzle_pkg;

	// Tile 0 is the blank
	typedef logic [`TILE_W-1:0] tile_t;
	typedef logic [$clog2(`BOARD_SIZE)-1:0] pos_t;
	typedef logic [`COUNT_W-1:0] count_t;

	// Index is the row-major position
	typedef tile_t [`BOARD_SIZE-1:0] board_t;

	typedef enum logic [0:0] {CMD_LOAD, CMD_MOVE} cmd_op_t;
	typedef enum logic [1:0] {DIR_UP, DIR_DOWN, DIR_RIGHT, DIR_LEFT} dir_t;
	typedef enum logic [1:0] {ST_OK, ST_ILLEGAL, ST_SOLVED} status_t;

	typedef struct packed {
		cmd_op_t op;
		dir_t dir;
		board_t board;
	} move_cmd_t;

	typedef struct packed {
		status_t status;
		count_t count;
		board_t board;
	} move_result_t;

	// Tiles 1..8 in order, blank in the last position
	function automatic board_t goal_board();
		board_t b;
		for (int i = 0; i < `BOARD_SIZE; i++) begin
			b[i] = tile_t'((i + 1) % `BOARD_SIZE);
		end
		return b;
	endfunction

	localparam board_t GOAL_BOARD = goal_board();

endpackage

`default_nettype wire

// File: src/puzzle_defines.svh
`ifndef PUZZLE_DEFINES_SVH
`define PUZZLE_DEFINES_SVH

// Board geometry
`define TILE_W 4
`define BOARD_SIZE 9
`define GRID_W 3

// Saturating move counter
`define COUNT_W 8

// Input FIFO depth doubles as the upstream credit grant
`define MOVE_FIFO_DEPTH 4

`define RESULT_FIFO_DEPTH 4
`define RESULT_CREDITS 4

`endif
